// File: logic/ip_mux_pkg.sv
`default_nettype none

package ip_mux_pkg;

    // payload beat width, one byte per beat
    localparam int DATA_W = 8;

    // IPv4 total length field
    localparam int IP_LEN_W = 16;

    // time-to-live field
    localparam int IP_TTL_W = 8;

    // protocol number field
    localparam int IP_PROTO_W = 8;

    // source and destination addresses
    localparam int IP_ADDR_W = 32;

    // two inputs need a single select bit
    localparam int SEL_W = 1;

endpackage

`default_nettype wire

// File: logic/ip_payload_if.sv
`timescale 1ns/100ps
`default_nettype none

// payload beats from the frame arbiter into the output skid stage
interface ip_payload_if;
    import ip_mux_pkg::*;

    logic [DATA_W-1:0] data;
    logic              valid;
    logic              last;
    logic              user;

    // skid stage can take a beat in the next cycle
    logic              ready_early;

    modport source (
        output data,
        output valid,
        output last,
        output user,
        input  ready_early
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        input  user,
        output ready_early
    );

endinterface

`default_nettype wire

// File: logic/ip_frame_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module ip_frame_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic [ip_mux_pkg::SEL_W-1:0]      select,

    input  logic                              in0_hdr_valid,
    output logic                              in0_hdr_ready,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]   in0_ip_length,
    input  logic [ip_mux_pkg::IP_TTL_W-1:0]   in0_ip_ttl,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0] in0_ip_protocol,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in0_ip_source_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in0_ip_dest_ip,
    input  logic [ip_mux_pkg::DATA_W-1:0]     in0_payload_data,
    input  logic                              in0_payload_valid,
    output logic                              in0_payload_ready,
    input  logic                              in0_payload_last,
    input  logic                              in0_payload_user,

    input  logic                              in1_hdr_valid,
    output logic                              in1_hdr_ready,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]   in1_ip_length,
    input  logic [ip_mux_pkg::IP_TTL_W-1:0]   in1_ip_ttl,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0] in1_ip_protocol,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in1_ip_source_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in1_ip_dest_ip,
    input  logic [ip_mux_pkg::DATA_W-1:0]     in1_payload_data,
    input  logic                              in1_payload_valid,
    output logic                              in1_payload_ready,
    input  logic                              in1_payload_last,
    input  logic                              in1_payload_user,

    output logic                              out_hdr_valid,
    input  logic                              out_hdr_ready,
    output logic [ip_mux_pkg::IP_LEN_W-1:0]   out_ip_length,
    output logic [ip_mux_pkg::IP_TTL_W-1:0]   out_ip_ttl,
    output logic [ip_mux_pkg::IP_PROTO_W-1:0] out_ip_protocol,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_source_ip,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_dest_ip,

    ip_payload_if.source                      payload
);
    import ip_mux_pkg::*;

    // frame state and the select latched at header time
    logic [SEL_W-1:0] select_reg;
    logic [SEL_W-1:0] select_next;
    logic             frame_reg;
    logic             frame_next;

    logic             in0_hdr_ready_next;
    logic             in1_hdr_ready_next;
    logic             in0_payload_ready_next;
    logic             in1_payload_ready_next;
    logic             out_hdr_valid_next;
    logic             hdr_load;

    // header of the input named by the live select
    logic                  sel_hdr_valid;
    logic [IP_LEN_W-1:0]   sel_length;
    logic [IP_TTL_W-1:0]   sel_ttl;
    logic [IP_PROTO_W-1:0] sel_protocol;
    logic [IP_ADDR_W-1:0]  sel_source_ip;
    logic [IP_ADDR_W-1:0]  sel_dest_ip;

    // payload of the input named by the latched select
    logic [DATA_W-1:0] cur_data;
    logic              cur_valid;
    logic              cur_ready;
    logic              cur_last;
    logic              cur_user;

    always_comb begin
        if (select == '0) begin
            sel_hdr_valid = in0_hdr_valid;
            sel_length    = in0_ip_length;
            sel_ttl       = in0_ip_ttl;
            sel_protocol  = in0_ip_protocol;
            sel_source_ip = in0_ip_source_ip;
            sel_dest_ip   = in0_ip_dest_ip;
        end else begin
            sel_hdr_valid = in1_hdr_valid;
            sel_length    = in1_ip_length;
            sel_ttl       = in1_ip_ttl;
            sel_protocol  = in1_ip_protocol;
            sel_source_ip = in1_ip_source_ip;
            sel_dest_ip   = in1_ip_dest_ip;
        end
    end

    always_comb begin
        if (select_reg == '0) begin
            cur_data  = in0_payload_data;
            cur_valid = in0_payload_valid;
            cur_ready = in0_payload_ready;
            cur_last  = in0_payload_last;
            cur_user  = in0_payload_user;
        end else begin
            cur_data  = in1_payload_data;
            cur_valid = in1_payload_valid;
            cur_ready = in1_payload_ready;
            cur_last  = in1_payload_last;
            cur_user  = in1_payload_user;
        end
    end

    always_comb begin
        select_next        = select_reg;
        frame_next         = frame_reg;
        hdr_load           = 1'b0;
        in0_hdr_ready_next = 1'b0;
        in1_hdr_ready_next = 1'b0;
        out_hdr_valid_next = out_hdr_valid & ~out_hdr_ready;

        if (frame_reg) begin
            // frame ends on an accepted last beat
            if (cur_valid & cur_ready) begin
                frame_next = ~cur_last;
            end
        end else if (enable & ~out_hdr_valid & sel_hdr_valid) begin
            frame_next         = 1'b1;
            select_next        = select;
            hdr_load           = 1'b1;
            out_hdr_valid_next = 1'b1;
            if (select == '0) begin
                in0_hdr_ready_next = 1'b1;
            end else begin
                in1_hdr_ready_next = 1'b1;
            end
        end

        // only the port owning the open frame may see ready
        in0_payload_ready_next = payload.ready_early & frame_next & (select_next == '0);
        in1_payload_ready_next = payload.ready_early & frame_next & (select_next != '0);
    end

    // beats go out only when actually taken from the input
    assign payload.data  = cur_data;
    assign payload.valid = cur_valid & cur_ready & frame_reg;
    assign payload.last  = cur_last;
    assign payload.user  = cur_user;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            select_reg        <= '0;
            frame_reg         <= 1'b0;
            in0_hdr_ready     <= 1'b0;
            in1_hdr_ready     <= 1'b0;
            in0_payload_ready <= 1'b0;
            in1_payload_ready <= 1'b0;
            out_hdr_valid     <= 1'b0;
        end else begin
            select_reg        <= select_next;
            frame_reg         <= frame_next;
            in0_hdr_ready     <= in0_hdr_ready_next;
            in1_hdr_ready     <= in1_hdr_ready_next;
            in0_payload_ready <= in0_payload_ready_next;
            in1_payload_ready <= in1_payload_ready_next;
            out_hdr_valid     <= out_hdr_valid_next;
        end
    end

    // header fields only change on capture
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            out_ip_length    <= sel_length;
            out_ip_ttl       <= sel_ttl;
            out_ip_protocol  <= sel_protocol;
            out_ip_source_ip <= sel_source_ip;
            out_ip_dest_ip   <= sel_dest_ip;
        end
    end

endmodule

`default_nettype wire

// File: logic/ip_payload_skid_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module ip_payload_skid_buffer (
    input  logic                          clk,
    input  logic                          rst,
    ip_payload_if.sink                    payload,
    output logic [ip_mux_pkg::DATA_W-1:0] out_payload_data,
    output logic                          out_payload_valid,
    input  logic                          out_payload_ready,
    output logic                          out_payload_last,
    output logic                          out_payload_user
);
    import ip_mux_pkg::*;

    // second slot, filled while the output is stalled
    logic [DATA_W-1:0] temp_data;
    logic              temp_valid;
    logic              temp_last;
    logic              temp_user;

    // ready_early one cycle late, tells if the arbiter may send now
    logic ready_reg;

    logic out_valid_next;
    logic temp_valid_next;
    logic load_out_from_in;
    logic load_temp_from_in;
    logic load_out_from_temp;

    // room next cycle if output drains, both slots empty,
    // or temp empty and nothing arriving to fill it
    assign payload.ready_early = out_payload_ready
                               | (~temp_valid & ~out_payload_valid)
                               | (~temp_valid & ~payload.valid);

    always_comb begin
        out_valid_next     = out_payload_valid;
        temp_valid_next    = temp_valid;
        load_out_from_in   = 1'b0;
        load_temp_from_in  = 1'b0;
        load_out_from_temp = 1'b0;

        if (ready_reg) begin
            if (out_payload_ready | ~out_payload_valid) begin
                out_valid_next   = payload.valid;
                load_out_from_in = 1'b1;
            end else begin
                // output stalled, park the arriving beat
                temp_valid_next   = payload.valid;
                load_temp_from_in = 1'b1;
            end
        end else if (out_payload_ready) begin
            out_valid_next     = temp_valid;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_reg         <= 1'b0;
            out_payload_valid <= 1'b0;
            temp_valid        <= 1'b0;
        end else begin
            ready_reg         <= payload.ready_early;
            out_payload_valid <= out_valid_next;
            temp_valid        <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_payload_data <= payload.data;
            out_payload_last <= payload.last;
            out_payload_user <= payload.user;
        end else if (load_out_from_temp) begin
            out_payload_data <= temp_data;
            out_payload_last <= temp_last;
            out_payload_user <= temp_user;
        end
        if (load_temp_from_in) begin
            temp_data <= payload.data;
            temp_last <= payload.last;
            temp_user <= payload.user;
        end
    end

endmodule

`default_nettype wire

// File: logic/ip_mux_top.sv
`timescale 1ns/100ps
`default_nettype none

// two-input IP frame mux, header capture plus skid-buffered payload
module ip_mux_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic [ip_mux_pkg::SEL_W-1:0]      select,

    input  logic                              in0_hdr_valid,
    output logic                              in0_hdr_ready,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]   in0_ip_length,
    input  logic [ip_mux_pkg::IP_TTL_W-1:0]   in0_ip_ttl,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0] in0_ip_protocol,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in0_ip_source_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in0_ip_dest_ip,
    input  logic [ip_mux_pkg::DATA_W-1:0]     in0_payload_data,
    input  logic                              in0_payload_valid,
    output logic                              in0_payload_ready,
    input  logic                              in0_payload_last,
    input  logic                              in0_payload_user,

    input  logic                              in1_hdr_valid,
    output logic                              in1_hdr_ready,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]   in1_ip_length,
    input  logic [ip_mux_pkg::IP_TTL_W-1:0]   in1_ip_ttl,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0] in1_ip_protocol,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in1_ip_source_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  in1_ip_dest_ip,
    input  logic [ip_mux_pkg::DATA_W-1:0]     in1_payload_data,
    input  logic                              in1_payload_valid,
    output logic                              in1_payload_ready,
    input  logic                              in1_payload_last,
    input  logic                              in1_payload_user,

    output logic                              out_hdr_valid,
    input  logic                              out_hdr_ready,
    output logic [ip_mux_pkg::IP_LEN_W-1:0]   out_ip_length,
    output logic [ip_mux_pkg::IP_TTL_W-1:0]   out_ip_ttl,
    output logic [ip_mux_pkg::IP_PROTO_W-1:0] out_ip_protocol,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_source_ip,
    output logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_dest_ip,
    output logic [ip_mux_pkg::DATA_W-1:0]     out_payload_data,
    output logic                              out_payload_valid,
    input  logic                              out_payload_ready,
    output logic                              out_payload_last,
    output logic                              out_payload_user
);

    // arbiter to skid stage
    ip_payload_if payload ();

    ip_frame_arbiter ip_frame_arbiter_inst (
        .clk               (clk),
        .rst               (rst),
        .enable            (enable),
        .select            (select),
        .in0_hdr_valid     (in0_hdr_valid),
        .in0_hdr_ready     (in0_hdr_ready),
        .in0_ip_length     (in0_ip_length),
        .in0_ip_ttl        (in0_ip_ttl),
        .in0_ip_protocol   (in0_ip_protocol),
        .in0_ip_source_ip  (in0_ip_source_ip),
        .in0_ip_dest_ip    (in0_ip_dest_ip),
        .in0_payload_data  (in0_payload_data),
        .in0_payload_valid (in0_payload_valid),
        .in0_payload_ready (in0_payload_ready),
        .in0_payload_last  (in0_payload_last),
        .in0_payload_user  (in0_payload_user),
        .in1_hdr_valid     (in1_hdr_valid),
        .in1_hdr_ready     (in1_hdr_ready),
        .in1_ip_length     (in1_ip_length),
        .in1_ip_ttl        (in1_ip_ttl),
        .in1_ip_protocol   (in1_ip_protocol),
        .in1_ip_source_ip  (in1_ip_source_ip),
        .in1_ip_dest_ip    (in1_ip_dest_ip),
        .in1_payload_data  (in1_payload_data),
        .in1_payload_valid (in1_payload_valid),
        .in1_payload_ready (in1_payload_ready),
        .in1_payload_last  (in1_payload_last),
        .in1_payload_user  (in1_payload_user),
        .out_hdr_valid     (out_hdr_valid),
        .out_hdr_ready     (out_hdr_ready),
        .out_ip_length     (out_ip_length),
        .out_ip_ttl        (out_ip_ttl),
        .out_ip_protocol   (out_ip_protocol),
        .out_ip_source_ip  (out_ip_source_ip),
        .out_ip_dest_ip    (out_ip_dest_ip),
        .payload           (payload.source)
    );

    ip_payload_skid_buffer ip_payload_skid_buffer_inst (
        .clk               (clk),
        .rst               (rst),
        .payload           (payload.sink),
        .out_payload_data  (out_payload_data),
        .out_payload_valid (out_payload_valid),
        .out_payload_ready (out_payload_ready),
        .out_payload_last  (out_payload_last),
        .out_payload_user  (out_payload_user)
    );

endmodule

`default_nettype wire

// File: verification/ip_mux_assertions.sv
`timescale 1ns/100ps
`default_nettype none

// protocol rules on the mux top level, attached by bind
module ip_mux_assertions (
    input logic                              clk,
    input logic                              rst,
    input logic                              in0_hdr_ready,
    input logic                              in1_hdr_ready,
    input logic                              in0_payload_ready,
    input logic                              in1_payload_ready,
    input logic                              out_hdr_valid,
    input logic                              out_hdr_ready,
    input logic [ip_mux_pkg::IP_LEN_W-1:0]   out_ip_length,
    input logic [ip_mux_pkg::IP_TTL_W-1:0]   out_ip_ttl,
    input logic [ip_mux_pkg::IP_PROTO_W-1:0] out_ip_protocol,
    input logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_source_ip,
    input logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_dest_ip,
    input logic [ip_mux_pkg::DATA_W-1:0]     out_payload_data,
    input logic                              out_payload_valid,
    input logic                              out_payload_ready,
    input logic                              out_payload_last,
    input logic                              out_payload_user
);
    int failures = 0;

    // header waits unchanged for the sink
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid
            && $stable({out_ip_length, out_ip_ttl, out_ip_protocol,
                        out_ip_source_ip, out_ip_dest_ip}))
        else begin
            $error("output header changed before it was accepted");
            failures++;
        end

    payload_hold: assert property (@(posedge clk) disable iff (rst)
        out_payload_valid && !out_payload_ready |=> out_payload_valid
            && $stable({out_payload_data, out_payload_last, out_payload_user}))
        else begin
            $error("output payload beat changed while stalled");
            failures++;
        end

    // only the owner of the open frame sees ready
    payload_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        !(in0_payload_ready && in1_payload_ready))
        else begin
            $error("both inputs see payload ready");
            failures++;
        end

    hdr_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        !(in0_hdr_ready && in1_hdr_ready))
        else begin
            $error("both inputs see header ready");
            failures++;
        end

endmodule

`default_nettype wire

// File: verification/ip_mux_checker.sv
`timescale 1ns/100ps
`default_nettype none

// watches the mux output and compares against the expected frames
module ip_mux_checker (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              out_hdr_valid,
    input  logic                              out_hdr_ready,
    input  logic [ip_mux_pkg::IP_LEN_W-1:0]   out_ip_length,
    input  logic [ip_mux_pkg::IP_TTL_W-1:0]   out_ip_ttl,
    input  logic [ip_mux_pkg::IP_PROTO_W-1:0] out_ip_protocol,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_source_ip,
    input  logic [ip_mux_pkg::IP_ADDR_W-1:0]  out_ip_dest_ip,
    input  logic [ip_mux_pkg::DATA_W-1:0]     out_payload_data,
    input  logic                              out_payload_valid,
    input  logic                              out_payload_ready,
    input  logic                              out_payload_last,
    input  logic                              out_payload_user,
    output int                                errors,
    output int                                frames_done
);
    import ip_mux_pkg::*;

    logic [IP_LEN_W+IP_TTL_W+IP_PROTO_W+2*IP_ADDR_W-1:0] hdr_q [$];
    logic [IP_LEN_W+IP_TTL_W+IP_PROTO_W+2*IP_ADDR_W-1:0] hdr_seen;
    logic [IP_LEN_W+IP_TTL_W+IP_PROTO_W+2*IP_ADDR_W-1:0] hdr_exp;
    // beat word is {user, last, data}
    logic [DATA_W+1:0] beat_q [$];
    logic [DATA_W+1:0] beat_seen;
    logic [DATA_W+1:0] beat_exp;
    string test_name = "none";

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic push_header(input logic [IP_LEN_W+IP_TTL_W+IP_PROTO_W+2*IP_ADDR_W-1:0] hdr);
        hdr_q.push_back(hdr);
    endtask

    task automatic push_beat(input logic [DATA_W+1:0] beat);
        beat_q.push_back(beat);
    endtask

    function automatic int pending();
        return hdr_q.size() + beat_q.size();
    endfunction

    assign hdr_seen  = {out_ip_length, out_ip_ttl, out_ip_protocol,
                        out_ip_source_ip, out_ip_dest_ip};
    assign beat_seen = {out_payload_user, out_payload_last, out_payload_data};

    initial begin
        errors      = 0;
        frames_done = 0;
    end

    always @(posedge clk) begin
        if (!rst && out_hdr_valid && out_hdr_ready) begin
            if (hdr_q.size() == 0) begin
                $display("%s: output header appeared with no frame pending", test_name);
                errors++;
            end else begin
                hdr_exp = hdr_q.pop_front();
                if (hdr_seen !== hdr_exp) begin
                    $display("MISMATCH %s: header expected %h actual %h",
                             test_name, hdr_exp, hdr_seen);
                    errors++;
                end
            end
        end
        if (!rst && out_payload_valid && out_payload_ready) begin
            if (beat_q.size() == 0) begin
                $display("%s: output payload beat with no frame pending", test_name);
                errors++;
            end else begin
                beat_exp = beat_q.pop_front();
                if (beat_seen !== beat_exp) begin
                    $display("MISMATCH %s: beat expected %h actual %h",
                             test_name, beat_exp, beat_seen);
                    errors++;
                end
            end
            if (out_payload_last) begin
                frames_done++;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/ip_mux_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ip_mux_tb;
    import ip_mux_pkg::*;

    localparam int HDR_W      = IP_LEN_W + IP_TTL_W + IP_PROTO_W + 2 * IP_ADDR_W;
    localparam int WAIT_LIMIT = 300;
    localparam int DONE_LIMIT = 4000;
    localparam int MAX_FRAMES = 64;
    localparam int MAX_LEN    = 12;

    logic                  clk;
    logic                  rst;
    logic                  enable;
    logic [SEL_W-1:0]      select;
    // per-input stimulus, index is the port number
    logic [1:0]            hdr_valid;
    wire  [1:0]            hdr_ready;
    logic [HDR_W-1:0]      hdr_word [2];
    logic [DATA_W-1:0]     pl_data [2];
    logic [1:0]            pl_valid;
    wire  [1:0]            pl_ready;
    logic [1:0]            pl_last;
    logic [1:0]            pl_user;
    logic                  out_hdr_valid;
    logic                  out_hdr_ready;
    logic [IP_LEN_W-1:0]   out_ip_length;
    logic [IP_TTL_W-1:0]   out_ip_ttl;
    logic [IP_PROTO_W-1:0] out_ip_protocol;
    logic [IP_ADDR_W-1:0]  out_ip_source_ip;
    logic [IP_ADDR_W-1:0]  out_ip_dest_ip;
    logic [DATA_W-1:0]     out_payload_data;
    logic                  out_payload_valid;
    logic                  out_payload_ready;
    logic                  out_payload_last;
    logic                  out_payload_user;
    logic                  bp_mode = 1'b0;

    int    chk_errors;
    int    chk_frames;
    int    tb_errors = 0;
    int    errors_before = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    nframes = 0;
    int    f0;
    int    f1;
    int    fx;
    string cur_test = "none";

    // frames as issued
    logic [HDR_W-1:0]  stim_hdr [MAX_FRAMES];
    int                stim_len [MAX_FRAMES];
    logic [DATA_W-1:0] stim_data [MAX_FRAMES][MAX_LEN];
    logic              stim_err [MAX_FRAMES];

    bind ip_mux_top ip_mux_assertions ip_mux_assertions_inst (.*);

    ip_mux_top ip_mux_top_inst (
        .*,
        .in0_hdr_valid     (hdr_valid[0]),
        .in0_hdr_ready     (hdr_ready[0]),
        .in0_ip_length     (hdr_word[0][HDR_W-1 -: IP_LEN_W]),
        .in0_ip_ttl        (hdr_word[0][2*IP_ADDR_W+IP_PROTO_W +: IP_TTL_W]),
        .in0_ip_protocol   (hdr_word[0][2*IP_ADDR_W +: IP_PROTO_W]),
        .in0_ip_source_ip  (hdr_word[0][IP_ADDR_W +: IP_ADDR_W]),
        .in0_ip_dest_ip    (hdr_word[0][0 +: IP_ADDR_W]),
        .in0_payload_data  (pl_data[0]),
        .in0_payload_valid (pl_valid[0]),
        .in0_payload_ready (pl_ready[0]),
        .in0_payload_last  (pl_last[0]),
        .in0_payload_user  (pl_user[0]),
        .in1_hdr_valid     (hdr_valid[1]),
        .in1_hdr_ready     (hdr_ready[1]),
        .in1_ip_length     (hdr_word[1][HDR_W-1 -: IP_LEN_W]),
        .in1_ip_ttl        (hdr_word[1][2*IP_ADDR_W+IP_PROTO_W +: IP_TTL_W]),
        .in1_ip_protocol   (hdr_word[1][2*IP_ADDR_W +: IP_PROTO_W]),
        .in1_ip_source_ip  (hdr_word[1][IP_ADDR_W +: IP_ADDR_W]),
        .in1_ip_dest_ip    (hdr_word[1][0 +: IP_ADDR_W]),
        .in1_payload_data  (pl_data[1]),
        .in1_payload_valid (pl_valid[1]),
        .in1_payload_ready (pl_ready[1]),
        .in1_payload_last  (pl_last[1]),
        .in1_payload_user  (pl_user[1])
    );

    ip_mux_checker ip_mux_checker_inst (
        .*,
        .errors      (chk_errors),
        .frames_done (chk_frames)
    );

    // output word for beat idx of frame f: header passes through unchanged,
    // last marks the final byte and user only rides on that byte
    function automatic logic [HDR_W+DATA_W+1:0] expected_frame(input int f, input int idx);
        logic last;
        last = (idx == stim_len[f] - 1);
        return {stim_hdr[f], stim_err[f] & last, last, stim_data[f][idx]};
    endfunction

    function automatic int total_errors();
        return tb_errors + chk_errors + ip_mux_top_inst.ip_mux_assertions_inst.failures;
    endfunction

    task automatic abort_run(input string why);
        $display("%s: %s", cur_test, why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        errors_before = total_errors();
        ip_mux_checker_inst.set_test(name);
    endtask

    task automatic end_test();
        tests_run++;
        if (total_errors() == errors_before) begin
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", cur_test, total_errors() - errors_before);
        end
    endtask

    task automatic build_frame(input int len, output int f);
        logic [HDR_W+DATA_W+1:0] word;
        f = nframes;
        nframes++;
        stim_hdr[f] = {$urandom, $urandom, $urandom};
        stim_len[f] = len;
        stim_err[f] = 1'($urandom_range(1));
        for (int i = 0; i < len; i++) begin
            stim_data[f][i] = DATA_W'($urandom);
        end
        for (int i = 0; i < len; i++) begin
            word = expected_frame(f, i);
            if (i == 0) begin
                ip_mux_checker_inst.push_header(word[HDR_W+DATA_W+1 -: HDR_W]);
            end
            ip_mux_checker_inst.push_beat(word[DATA_W+1:0]);
        end
    endtask

    // called on a falling edge, returns on the falling edge before the transfer
    task automatic wait_port_ready(input int port, input bit for_header);
        int cycles;
        cycles = 0;
        while ((for_header ? hdr_ready[port] : pl_ready[port]) !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("input %0d never raised %s ready", port,
                                    for_header ? "header" : "payload"));
            end
        end
    endtask

    task automatic send_frame(input int port, input int f);
        select = SEL_W'(port);
        hdr_word[port] = stim_hdr[f];
        hdr_valid[port] = 1'b1;
        wait_port_ready(port, 1'b1);
        @(negedge clk);
        hdr_valid[port] = 1'b0;
        for (int i = 0; i < stim_len[f]; i++) begin
            if ($urandom_range(3) == 0) begin
                pl_valid[port] = 1'b0;
                @(negedge clk);
            end
            pl_data[port]  = stim_data[f][i];
            pl_last[port]  = (i == stim_len[f] - 1);
            pl_user[port]  = stim_err[f] && (i == stim_len[f] - 1);
            pl_valid[port] = 1'b1;
            wait_port_ready(port, 1'b0);
            @(negedge clk);
        end
        pl_valid[port] = 1'b0;
        pl_last[port]  = 1'b0;
    endtask

    task automatic wait_checker_done();
        int cycles;
        cycles = 0;
        while (chk_frames < nframes || ip_mux_checker_inst.pending() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > DONE_LIMIT) begin
                abort_run("output frames did not all arrive in time");
            end
        end
    endtask

    // unknown values count as a failure here
    task automatic check_idle_outputs(input string when);
        if (hdr_ready !== 2'b00 || pl_ready !== 2'b00
                || out_hdr_valid !== 1'b0 || out_payload_valid !== 1'b0) begin
            $display("%s: a ready or valid output is not low %s", cur_test, when);
            tb_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sink side of the output, random stalls only in back-pressure mode
    initial begin
        out_hdr_ready = 1'b1;
        out_payload_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (bp_mode) begin
                out_hdr_ready = ($urandom_range(3) != 0);
                out_payload_ready = ($urandom_range(1) != 0);
            end else begin
                out_hdr_ready = 1'b1;
                out_payload_ready = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(4762));
        rst = 1'b1;
        enable = 1'b1;
        select = '0;
        hdr_valid = '0;
        pl_valid = '0;
        pl_last = '0;
        pl_user = '0;
        for (int p = 0; p < 2; p++) begin
            hdr_word[p] = '0;
            pl_data[p] = '0;
        end

        begin_test("reset_state");
        repeat (8) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs("after reset");
        end
        end_test();

        begin_test("header_routing");
        build_frame($urandom_range(1, MAX_LEN), fx);
        send_frame(0, fx);
        build_frame($urandom_range(1, MAX_LEN), fx);
        send_frame(1, fx);
        wait_checker_done();
        end_test();

        // single-byte frames on both inputs first
        begin_test("payload_integrity");
        for (int i = 0; i < 6; i++) begin
            build_frame((i < 2) ? 1 : $urandom_range(2, MAX_LEN), fx);
            send_frame(i % 2, fx);
        end
        wait_checker_done();
        end_test();

        begin_test("enable_gating");
        enable = 1'b0;
        build_frame($urandom_range(1, MAX_LEN), fx);
        fork
            send_frame(1, fx);
            begin
                repeat (20) begin
                    @(negedge clk);
                    if (hdr_ready != 2'b00 || out_hdr_valid) begin
                        $display("%s: header taken while enable was low", cur_test);
                        tb_errors++;
                    end
                end
                enable = 1'b1;
            end
        join
        wait_checker_done();
        end_test();

        // input 1 waits with its header while select flips mid-frame
        begin_test("frame_atomicity");
        build_frame(MAX_LEN, f0);
        build_frame($urandom_range(1, MAX_LEN), f1);
        fork
            send_frame(0, f0);
            begin
                wait_port_ready(0, 1'b1);
                send_frame(1, f1);
            end
        join
        wait_checker_done();
        end_test();

        begin_test("back_pressure");
        bp_mode = 1'b1;
        for (int i = 0; i < 10; i++) begin
            build_frame($urandom_range(1, MAX_LEN), fx);
            send_frame($urandom_range(1), fx);
        end
        wait_checker_done();
        bp_mode = 1'b0;
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/ip_mux_pkg.sv
logic/ip_payload_if.sv
logic/ip_frame_arbiter.sv
logic/ip_payload_skid_buffer.sv
logic/ip_mux_top.sv
verification/ip_mux_assertions.sv
verification/ip_mux_checker.sv
verification/ip_mux_tb.sv

// File: Bender.yml
package:
  name: ip_mux

sources:
  # synthesizable design, package first
  - logic/ip_mux_pkg.sv
  - logic/ip_payload_if.sv
  - logic/ip_frame_arbiter.sv
  - logic/ip_payload_skid_buffer.sv
  - logic/ip_mux_top.sv

  # testbench, top module ip_mux_tb
  - target: test
    files:
      - verification/ip_mux_assertions.sv
      - verification/ip_mux_checker.sv
      - verification/ip_mux_tb.sv
